/* logic/fp16_pkg.sv */
`default_nettype none

package fp16_pkg;

  // binary16 format
  localparam int EXP_BIAS = 15;
  localparam int EXP_MAX  = 31;
  localparam int SIG_W    = 11;
  localparam int PROD_W   = 22;

  // canonical quiet NaN
  localparam logic [15:0] QNAN = 16'h7e00;

  // register offsets
  localparam logic [3:0] ADDR_OP_A   = 4'h0;
  localparam logic [3:0] ADDR_OP_B   = 4'h4;
  localparam logic [3:0] ADDR_CTRL   = 4'h8;
  localparam logic [3:0] ADDR_RESULT = 4'hc;

  localparam int RESULT_BUSY_BIT = 31;

  typedef struct packed {
    logic       sign;
    logic [4:0] exp;
    logic [9:0] frac;
  } fp16_t;

  typedef enum logic [1:0] {
    ST_ZERO  = 2'd0,
    ST_INF   = 2'd1,
    ST_NAN   = 2'd2,
    ST_VALID = 2'd3
  } fp_status_e;

  typedef struct packed {
    logic  valid;
    fp16_t a;
    fp16_t b;
  } mul_req_t;

  typedef struct packed {
    logic       valid;
    fp16_t      result;
    fp_status_e status;
  } mul_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

/* logic/wallace_mult_11x11.sv */
`timescale 1ns/1ps
`default_nettype none

module wallace_mult_11x11 (
  input  logic [10:0] a,
  input  logic [10:0] b,
  output logic [21:0] p
);
  import fp16_pkg::*;

  localparam int COLS   = PROD_W;
  localparam int HMAX   = 12;
  // column heights go 11, 8, 5, 4, 3, 2
  localparam int STAGES = 5;

  logic [HMAX-1:0] cur [COLS];
  logic [HMAX-1:0] nxt [COLS];
  int              cur_h [COLS];
  int              nxt_h [COLS];
  logic [COLS-1:0] row0;
  logic [COLS-1:0] row1;
  logic [COLS-1:0] cy;

  always_comb begin
    for (int k = 0; k < COLS; k++) begin
      cur[k]   = '0;
      cur_h[k] = 0;
    end
    // partial product a[i]&b[j] lands in column i+j
    for (int i = 0; i < SIG_W; i++) begin
      for (int j = 0; j < SIG_W; j++) begin
        cur[i+j][cur_h[i+j]] = a[i] & b[j];
        cur_h[i+j] = cur_h[i+j] + 1;
      end
    end

    for (int s = 0; s < STAGES; s++) begin
      for (int k = 0; k < COLS; k++) begin
        nxt[k]   = '0;
        nxt_h[k] = 0;
      end
      for (int k = 0; k < COLS; k++) begin
        // 3:2 compressor on every full triple of the column
        for (int t = 0; t + 2 < HMAX; t += 3) begin
          if (t + 2 < cur_h[k]) begin
            nxt[k][nxt_h[k]] = cur[k][t] ^ cur[k][t+1] ^ cur[k][t+2];
            nxt_h[k] = nxt_h[k] + 1;
            if (k + 1 < COLS) begin
              nxt[k+1][nxt_h[k+1]] = (cur[k][t] & cur[k][t+1]) |
                                     (cur[k][t+2] & (cur[k][t] ^ cur[k][t+1]));
              nxt_h[k+1] = nxt_h[k+1] + 1;
            end
          end
        end
        // leftover pair through a 2:2, a lone bit passes
        if (cur_h[k] % 3 == 2) begin
          nxt[k][nxt_h[k]] = cur[k][cur_h[k]-2] ^ cur[k][cur_h[k]-1];
          nxt_h[k] = nxt_h[k] + 1;
          if (k + 1 < COLS) begin
            nxt[k+1][nxt_h[k+1]] = cur[k][cur_h[k]-2] & cur[k][cur_h[k]-1];
            nxt_h[k+1] = nxt_h[k+1] + 1;
          end
        end else if (cur_h[k] % 3 == 1) begin
          nxt[k][nxt_h[k]] = cur[k][cur_h[k]-1];
          nxt_h[k] = nxt_h[k] + 1;
        end
      end
      cur   = nxt;
      cur_h = nxt_h;
    end

    // at most two bits left per column
    for (int k = 0; k < COLS; k++) begin
      row0[k] = cur[k][0];
      row1[k] = cur[k][1];
    end
  end

  // final carry-propagate merge
  always_comb begin
    cy[0] = 1'b0;
    for (int k = 0; k < COLS; k++) begin
      p[k] = row0[k] ^ row1[k] ^ cy[k];
      if (k + 1 < COLS) begin
        cy[k+1] = (row0[k] & row1[k]) | (cy[k] & (row0[k] ^ row1[k]));
      end
    end
  end

endmodule

`default_nettype wire

/* logic/fp16_round_norm.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_round_norm (
  input  logic [21:0]       prod,
  input  logic signed [7:0] exp_sum,
  input  logic              sign,
  output fp16_pkg::fp16_t   res,
  output logic              ovf,
  output logic              unf
);
  import fp16_pkg::*;

  logic              shift;
  logic [9:0]        mant;
  logic              guard;
  logic              sticky;
  logic              round_up;
  logic [10:0]       mant_r;
  logic signed [9:0] exp_fin;

  // significand product is in [1,4), shift once when it reaches 2
  assign shift  = prod[PROD_W-1];
  assign mant   = shift ? prod[20:11] : prod[19:10];
  assign guard  = shift ? prod[10] : prod[9];
  assign sticky = shift ? |prod[9:0] : |prod[8:0];

  // ties go to the even kept value
  assign round_up = guard & (sticky | mant[0]);
  assign mant_r   = {1'b0, mant} + 11'(round_up);

  // all-ones fraction rounding up gives 1.0 at the next exponent
  assign exp_fin = 10'(exp_sum) + 10'(EXP_BIAS) + 10'(shift) + 10'(mant_r[10]);

  assign ovf = exp_fin >= EXP_MAX;
  assign unf = exp_fin <= 0;

  assign res = '{sign: sign, exp: exp_fin[4:0], frac: mant_r[9:0]};

endmodule

`default_nettype wire

/* logic/fp16_mul_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_mul_pipe (
  input  logic               clk,
  input  logic               rst,
  input  fp16_pkg::mul_req_t req,
  output fp16_pkg::mul_rsp_t rsp
);
  import fp16_pkg::*;

  logic              a_zero;
  logic              a_inf;
  logic              a_nan;
  logic              b_zero;
  logic              b_inf;
  logic              b_nan;
  fp_status_e        code;
  logic [SIG_W-1:0]  sig_a;
  logic [SIG_W-1:0]  sig_b;
  logic [PROD_W-1:0] prod;

  logic              s1_valid;
  logic              s1_sign;
  logic signed [7:0] s1_exp_sum;
  logic [PROD_W-1:0] s1_prod;
  fp_status_e        s1_code;

  fp16_t             rn_res;
  logic              rn_ovf;
  logic              rn_unf;
  fp16_t             res_d;
  fp_status_e        st_d;

  logic              rsp_valid;
  fp16_t             rsp_result;
  fp_status_e        rsp_status;

  // subnormals count as zero
  assign a_zero = req.a.exp == '0;
  assign b_zero = req.b.exp == '0;
  assign a_inf  = (req.a.exp == '1) && (req.a.frac == '0);
  assign b_inf  = (req.b.exp == '1) && (req.b.frac == '0);
  assign a_nan  = (req.a.exp == '1) && (req.a.frac != '0);
  assign b_nan  = (req.b.exp == '1) && (req.b.frac != '0);

  // ST_VALID here means both operands are normal
  always_comb begin
    if (a_nan || b_nan || (a_zero && b_inf) || (a_inf && b_zero)) begin
      code = ST_NAN;
    end else if (a_inf || b_inf) begin
      code = ST_INF;
    end else if (a_zero || b_zero) begin
      code = ST_ZERO;
    end else begin
      code = ST_VALID;
    end
  end

  assign sig_a = {1'b1, req.a.frac};
  assign sig_b = {1'b1, req.b.frac};

  wallace_mult_11x11 mult_i (
    .a (sig_a),
    .b (sig_b),
    .p (prod)
  );

  always_ff @(posedge clk) begin
    s1_sign    <= req.a.sign ^ req.b.sign;
    s1_exp_sum <= $signed({3'b000, req.a.exp}) + $signed({3'b000, req.b.exp}) -
                  8'(2 * EXP_BIAS);
    s1_prod    <= prod;
    s1_code    <= code;
  end

  fp16_round_norm round_i (
    .prod    (s1_prod),
    .exp_sum (s1_exp_sum),
    .sign    (s1_sign),
    .res     (rn_res),
    .ovf     (rn_ovf),
    .unf     (rn_unf)
  );

  always_comb begin
    res_d      = rn_res;
    st_d       = ST_VALID;
    case (s1_code)
      ST_NAN: begin
        res_d = fp16_t'(QNAN);
        st_d  = ST_NAN;
      end
      ST_INF: begin
        res_d = '{sign: s1_sign, exp: '1, frac: '0};
        st_d  = ST_INF;
      end
      ST_ZERO: begin
        res_d = '{sign: s1_sign, exp: '0, frac: '0};
        st_d  = ST_ZERO;
      end
      default: begin
        if (rn_ovf) begin
          res_d = '{sign: s1_sign, exp: '1, frac: '0};
          st_d  = ST_INF;
        end else if (rn_unf) begin
          res_d = '{sign: s1_sign, exp: '0, frac: '0};
          st_d  = ST_ZERO;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid  <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      s1_valid  <= req.valid;
      rsp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_result <= res_d;
    rsp_status <= st_d;
  end

  assign rsp = '{valid: rsp_valid, result: rsp_result, status: rsp_status};

endmodule

`default_nettype wire

/* logic/apb_fp16_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_fp16_regs (
  input  logic               clk,
  input  logic               rst,
  input  fp16_pkg::apb_req_t apb_req,
  output fp16_pkg::apb_rsp_t apb_rsp,
  output fp16_pkg::mul_req_t mul_req,
  input  fp16_pkg::mul_rsp_t mul_rsp
);
  import fp16_pkg::*;

  fp16_t       op_a;
  fp16_t       op_b;
  fp16_t       result;
  fp_status_e  status;
  logic        busy;
  logic        launch_q;

  logic        access;
  logic        is_ctrl;
  logic        is_result;
  logic        addr_hit;
  logic        stall;
  logic        done;
  logic        wr_done;
  logic        go;
  logic        err;
  logic [31:0] rdata;

  assign access    = apb_req.psel & apb_req.penable;
  assign is_ctrl   = apb_req.paddr == ADDR_CTRL;
  assign is_result = apb_req.paddr == ADDR_RESULT;
  assign addr_hit  = (apb_req.paddr == ADDR_OP_A) | (apb_req.paddr == ADDR_OP_B) |
                     is_ctrl | is_result;

  // result read waits until the in-flight product lands
  assign stall   = is_result & ~apb_req.pwrite & busy;
  assign done    = access & ~stall;
  assign wr_done = done & apb_req.pwrite;
  assign go      = wr_done & is_ctrl & apb_req.pwdata[0] & ~busy;

  assign err = ~addr_hit |
               (apb_req.pwrite & is_result) |
               (apb_req.pwrite & is_ctrl & apb_req.pwdata[0] & busy);

  always_ff @(posedge clk) begin
    if (rst) begin
      op_a     <= '0;
      op_b     <= '0;
      result   <= '0;
      status   <= ST_ZERO;
      busy     <= 1'b0;
      launch_q <= 1'b0;
    end else begin
      launch_q <= go;
      if (wr_done && apb_req.paddr == ADDR_OP_A) begin
        op_a <= fp16_t'(apb_req.pwdata[15:0]);
      end
      if (wr_done && apb_req.paddr == ADDR_OP_B) begin
        op_b <= fp16_t'(apb_req.pwdata[15:0]);
      end
      // launch is refused while busy, so set and clear never meet
      if (go) begin
        busy <= 1'b1;
      end else if (mul_rsp.valid) begin
        busy <= 1'b0;
      end
      if (mul_rsp.valid) begin
        result <= mul_rsp.result;
        status <= mul_rsp.status;
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (apb_req.paddr)
      ADDR_OP_A: rdata[15:0] = op_a;
      ADDR_OP_B: rdata[15:0] = op_b;
      ADDR_RESULT: begin
        rdata[15:0]            = result;
        rdata[17:16]           = status;
        rdata[RESULT_BUSY_BIT] = busy;
      end
      default: rdata = '0;
    endcase
  end

  assign apb_rsp = '{prdata: rdata, pready: ~stall, pslverr: done & err};

  // operands cannot change before the pipe samples the pulse
  assign mul_req = '{valid: launch_q, a: op_a, b: op_b};

endmodule

`default_nettype wire

/* logic/fp16_mul_apb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fp16_mul_apb_top (
  input  logic               clk,
  input  logic               rst,
  input  fp16_pkg::apb_req_t apb_req,
  output fp16_pkg::apb_rsp_t apb_rsp
);
  import fp16_pkg::*;

  mul_req_t mul_req;
  mul_rsp_t mul_rsp;

  apb_fp16_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .mul_req (mul_req),
    .mul_rsp (mul_rsp)
  );

  // two cycles from launch pulse to response
  fp16_mul_pipe pipe_i (
    .clk (clk),
    .rst (rst),
    .req (mul_req),
    .rsp (mul_rsp)
  );

endmodule

`default_nettype wire

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // two rising edges in reset, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

/* include/fp16_ref.svh */
`ifndef FP16_REF_SVH
`define FP16_REF_SVH

// next value of the random operand sequence
function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected {status, result}, laid out as in RESULT[17:0]
function automatic logic [17:0] fp16_ref_mul(input logic [15:0] a, input logic [15:0] b);
  logic sign;
  bit   a_zero;
  bit   b_zero;
  bit   a_inf;
  bit   b_inf;
  bit   a_nan;
  bit   b_nan;
  int   ea;
  int   eb;
  int   e;
  int   kept;
  int   biased;
  real  prod;
  real  scaled;
  real  rem;

  sign   = a[15] ^ b[15];
  ea     = a[14:10];
  eb     = b[14:10];
  a_zero = ea == 0;
  b_zero = eb == 0;
  a_inf  = (ea == 31) && (a[9:0] == 0);
  b_inf  = (eb == 31) && (b[9:0] == 0);
  a_nan  = (ea == 31) && (a[9:0] != 0);
  b_nan  = (eb == 31) && (b[9:0] != 0);

  if (a_nan || b_nan || (a_zero && b_inf) || (a_inf && b_zero)) begin
    return {fp16_pkg::ST_NAN, fp16_pkg::QNAN};
  end
  if (a_inf || b_inf) begin
    return {fp16_pkg::ST_INF, sign, 15'h7c00};
  end
  if (a_zero || b_zero) begin
    return {fp16_pkg::ST_ZERO, sign, 15'h0000};
  end

  // exact in double precision, 22 significant bits at most
  prod = real'((1024 + int'(a[9:0])) * (1024 + int'(b[9:0]))) * 2.0 ** (ea + eb - 50);
  e = -30;
  while (prod >= 2.0 ** (e + 1)) begin
    e++;
  end

  scaled = prod * 2.0 ** (10 - e);
  kept   = int'($floor(scaled));
  rem    = scaled - $floor(scaled);
  if (rem > 0.5 || (rem == 0.5 && kept % 2 == 1)) begin
    kept++;
  end
  if (kept == 2048) begin
    kept = 1024;
    e++;
  end

  biased = e + 15;
  if (biased >= 31) begin
    return {fp16_pkg::ST_INF, sign, 15'h7c00};
  end
  if (biased <= 0) begin
    return {fp16_pkg::ST_ZERO, sign, 15'h0000};
  end
  return {fp16_pkg::ST_VALID, sign, 5'(biased), 10'(kept - 1024)};
endfunction

`endif

/* test/tb_fp16_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fp16_mul;
  import fp16_pkg::*;

  `include "fp16_ref.svh"

  // about 600 operations at under 16 cycles each
  localparam int MAX_CYCLES = 10000;
  localparam int N_RANDOM   = 500;

  typedef struct packed {
    logic [31:0] got;
    logic [31:0] exp;
  } read_rec_t;

  logic        clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  read_rec_t   read_q [$];
  logic [15:0] special_ops [8];
  logic [31:0] seed;
  int          cycles;

  tb_clk_gen clk_gen_i (
    .clk (clk),
    .rst (rst)
  );

  fp16_mul_apb_top dut_i (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    $display("=== FAIL ===");
    $fatal(1, "value mismatch");
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] t=%0t %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1, "check failed");
  endtask

  // normal operand with its exponent kept near the bias
  function automatic logic [15:0] random_normal(input logic [15:0] r);
    return {r[15], 5'(7 + r[14:10] % 17), r[9:0]};
  endfunction

  // setup and access start on falling edges and the transfer ends at the first edge with pready
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output int waits);
    waits = 0;
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    while (!apb_rsp.pready) begin
      waits++;
      @(posedge clk);
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    apb_transfer(1'b1, addr, data, rdata, err, waits);
    assert (err == 1'b0) else report_mismatch("pslverr", 32'h0, 32'(err));
  endtask

  task automatic push_read(input logic [31:0] got, input logic [31:0] exp);
    read_rec_t rec;
    rec.got = got;
    rec.exp = exp;
    read_q.push_back(rec);
  endtask

  task automatic run_op(input logic [15:0] a, input logic [15:0] b, output int waits);
    logic [31:0] rdata;
    logic        err;
    write_reg(ADDR_OP_A, {16'h0, a});
    write_reg(ADDR_OP_B, {16'h0, b});
    write_reg(ADDR_CTRL, 32'h1);
    apb_transfer(1'b0, ADDR_RESULT, 32'h0, rdata, err, waits);
    assert (err == 1'b0) else report_mismatch("pslverr", 32'h0, 32'(err));
    push_read(rdata, 32'(fp16_ref_mul(a, b)));
  endtask

  initial begin : compare
    read_rec_t rec;
    forever begin
      @(negedge clk);
      while (read_q.size() > 0) begin
        rec = read_q.pop_front();
        assert (rec.got == rec.exp) else report_mismatch("prdata", rec.exp, rec.got);
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("timeout after %0d cycles, the tests did not finish", cycles);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rdata;
    logic        err;
    int          waits;
    logic [15:0] a;
    logic [15:0] b;

    apb_req     = '0;
    seed        = 32'h9eb5_87dc;
    // zeros, negative subnormal, infinities, NaN, two normals
    special_ops = '{16'h0000, 16'h8000, 16'h8001, 16'h7c00,
                    16'hfc00, 16'h7c01, 16'h3c00, 16'hc248};
    wait (rst == 1'b0);

    // RESULT straight out of reset
    apb_transfer(1'b0, ADDR_RESULT, 32'h0, rdata, err, waits);
    assert (err == 1'b0) else report_mismatch("pslverr", 32'h0, 32'(err));
    push_read(rdata, 32'h0);

    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8; j++) begin
        run_op(special_ops[i], special_ops[j], waits);
      end
    end

    repeat (N_RANDOM) begin
      seed = lcg_next(seed);
      a    = random_normal(seed[31:16]);
      seed = lcg_next(seed);
      b    = random_normal(seed[31:16]);
      run_op(a, b, waits);
    end

    // ties with odd and even kept bits on both sides of the normalize shift
    run_op(16'h3e00, 16'h3c01, waits);
    run_op(16'h3e00, 16'h3c03, waits);
    run_op(16'h3e00, 16'h3d56, waits);
    run_op(16'hbe00, 16'h3d5a, waits);
    // top of the range
    run_op(16'h7bff, 16'h3c00, waits);
    run_op(16'h7bff, 16'h3c01, waits);
    run_op(16'h5da8, 16'h59a8, waits);
    run_op(16'h79a8, 16'h79a8, waits);
    run_op(16'h79a8, 16'hf5a8, waits);
    // bottom of the range
    run_op(16'h0400, 16'h3c00, waits);
    run_op(16'h0400, 16'h3bff, waits);
    run_op(16'h21a8, 16'h1da8, waits);
    run_op(16'h8400, 16'h3800, waits);

    // RESULT read issued right behind the launch
    run_op(16'h4200, 16'h4500, waits);
    assert (waits >= 1) else report_failure("RESULT read after a launch was not stalled");

    apb_transfer(1'b1, 4'h2, 32'h0, rdata, err, waits);
    assert (err == 1'b1) else report_mismatch("pslverr", 32'h1, 32'(err));
    apb_transfer(1'b0, 4'h6, 32'h0, rdata, err, waits);
    assert (err == 1'b1) else report_mismatch("pslverr", 32'h1, 32'(err));
    apb_transfer(1'b1, ADDR_RESULT, 32'hffff, rdata, err, waits);
    assert (err == 1'b1) else report_mismatch("pslverr", 32'h1, 32'(err));

    // second launch lands while the first is in flight
    write_reg(ADDR_OP_A, 32'h4880);
    write_reg(ADDR_OP_B, 32'hbc40);
    write_reg(ADDR_CTRL, 32'h1);
    apb_transfer(1'b1, ADDR_CTRL, 32'h1, rdata, err, waits);
    assert (err == 1'b1) else report_mismatch("pslverr", 32'h1, 32'(err));
    apb_transfer(1'b0, ADDR_RESULT, 32'h0, rdata, err, waits);
    assert (err == 1'b0) else report_mismatch("pslverr", 32'h0, 32'(err));
    // nothing may be in flight once the refused launch has completed
    assert (waits == 0) else report_failure("refused CTRL launch started a new operation");
    push_read(rdata, 32'(fp16_ref_mul(16'h4880, 16'hbc40)));

    while (read_q.size() > 0) begin
      @(posedge clk);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
logic/fp16_pkg.sv
logic/wallace_mult_11x11.sv
logic/fp16_round_norm.sv
logic/fp16_mul_pipe.sv
logic/apb_fp16_regs.sv
logic/fp16_mul_apb_top.sv
test/tb_clk_gen.sv
test/tb_fp16_mul.sv
